//--- hw/fma_pkg.sv
package fma_pkg;

    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;
    localparam int EXP_BIAS = 127;
    localparam int QNAN_BIT = 22;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mantissa;
    } fp_fields_t;

    // raw view for constants and nan quieting, field view for arithmetic
    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  f;
    } fp_word_u;

    // codes 4 to 7 fall back to RNE
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3
    } round_mode_e;

    typedef struct packed {
        logic        valid;
        round_mode_e rounding_mode;
        logic        special_case;
        fp_word_u    special_result;
        logic        invalid;
        logic        flushed;
    } fma_side_t;

    typedef struct packed {
        logic              sign;
        logic signed [9:0] exponent;
        logic [47:0]       mant;
    } fma_prod_t;

    // hidden bit at 26, three extra bits below the lsb
    typedef struct packed {
        logic [26:0]       larger_mant;
        logic [26:0]       smaller_mant;
        logic              sticky;
        logic signed [9:0] exponent;
        logic              sign;
        logic              is_sub;
    } fma_align_t;

    typedef struct packed {
        logic [27:0]       sum;
        logic [26:0]       diff;
        logic              is_sub;
        logic              sticky;
        logic              exact_zero;
        logic signed [9:0] exponent;
        logic              sign;
    } fma_sum_t;

    typedef struct packed {
        logic overflow;
        logic underflow;
        logic inexact;
        logic invalid;
    } fma_flags_t;

endpackage

//--- hw/fma_classify.sv
`timescale 1ns/10ps

module fma_classify (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  fma_pkg::fp_word_u    in1,
    input  fma_pkg::fp_word_u    in2,
    input  fma_pkg::fp_word_u    in3,
    input  fma_pkg::round_mode_e rounding_mode,
    output fma_pkg::fma_side_t   side,
    output fma_pkg::fp_word_u    op_a,
    output fma_pkg::fp_word_u    op_b,
    output fma_pkg::fp_word_u    op_c
);

    fma_pkg::fp_word_u  in_ops [3];
    // denormals count as zero
    logic [2:0]         is_zero;
    logic [2:0]         is_dnrm;
    logic [2:0]         is_inf;
    logic [2:0]         is_qnan;
    logic [2:0]         is_snan;
    logic               prod_neg;
    logic               prod_inf;
    logic               prod_zero;
    logic               zero_sign;
    fma_pkg::fma_side_t side_d;

    assign in_ops[0] = in1;
    assign in_ops[1] = in2;
    assign in_ops[2] = in3;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            is_zero[i] = in_ops[i].f.exponent == '0;
            is_dnrm[i] = is_zero[i] && (in_ops[i].f.mantissa != '0);
            is_inf[i]  = (in_ops[i].f.exponent == '1) && (in_ops[i].f.mantissa == '0);
            is_qnan[i] = (in_ops[i].f.exponent == '1)
                         && in_ops[i].f.mantissa[fma_pkg::QNAN_BIT];
            is_snan[i] = (in_ops[i].f.exponent == '1) && (in_ops[i].f.mantissa != '0)
                         && !in_ops[i].f.mantissa[fma_pkg::QNAN_BIT];
        end
    end

    assign prod_neg  = in1.f.sign ^ in2.f.sign;
    assign prod_inf  = (is_inf[0] | is_inf[1]) & ~(is_zero[0] | is_zero[1]);
    assign prod_zero = is_zero[0] | is_zero[1];
    // zeros of opposite sign sum to +0, or -0 when rounding down
    assign zero_sign = (prod_neg == in3.f.sign) ? prod_neg
                                                : (rounding_mode == fma_pkg::RDN);

    always_comb begin
        side_d.valid              = valid_in;
        side_d.rounding_mode      = rounding_mode;
        side_d.flushed            = |is_dnrm;
        side_d.invalid            = (|is_snan) | (prod_zero & (is_inf[0] | is_inf[1]))
                                    | (prod_inf & is_inf[2] & (prod_neg ^ in3.f.sign));
        side_d.special_case       = 1'b1;
        side_d.special_result.raw = '0;
        if (|is_qnan) begin
            for (int i = 2; i >= 0; i--) begin
                if (is_qnan[i]) side_d.special_result = in_ops[i];
            end
        end else if (|is_snan) begin
            for (int i = 2; i >= 0; i--) begin
                if (is_snan[i]) begin
                    side_d.special_result.raw = in_ops[i].raw | (32'd1 << fma_pkg::QNAN_BIT);
                end
            end
        end else if (side_d.invalid) begin
            // default quiet nan for inf * 0 and inf - inf
            side_d.special_result.raw = 32'h7fc0_0000;
        end else if (prod_inf | is_inf[2]) begin
            side_d.special_result.f.sign     = prod_inf ? prod_neg : in3.f.sign;
            side_d.special_result.f.exponent = '1;
            side_d.special_result.f.mantissa = '0;
        end else if (prod_zero & is_zero[2]) begin
            side_d.special_result.raw = {zero_sign, 31'b0};
        end else if (prod_zero) begin
            side_d.special_result = in3;
        end else begin
            side_d.special_case = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side <= '0;
        end else begin
            side <= side_d;
        end
    end

    always_ff @(posedge clk) begin
        op_a <= in1;
        op_b <= in2;
        // zero addend carries no hidden bit downstream
        op_c <= in3;
        if (is_zero[2]) op_c.raw <= {in3.f.sign, 31'b0};
    end

endmodule

//--- hw/fma_multiplier.sv
`timescale 1ns/10ps

module fma_multiplier (
    input  logic               clk,
    input  logic               rst,
    input  fma_pkg::fma_side_t side_in,
    input  fma_pkg::fp_word_u  op_a,
    input  fma_pkg::fp_word_u  op_b,
    input  fma_pkg::fp_word_u  op_c_in,
    output fma_pkg::fma_side_t side,
    output fma_pkg::fma_prod_t prod,
    output fma_pkg::fp_word_u  op_c
);

    fma_pkg::fma_side_t side_q;
    fma_pkg::fp_word_u  op_c_q;
    logic               sign_q;
    logic signed [9:0]  exp_q;
    logic [35:0]        pp_lo_q;
    logic [35:0]        pp_hi_q;
    logic [23:0]        mant_a;
    logic [23:0]        mant_b;

    assign mant_a = {1'b1, op_a.f.mantissa};
    assign mant_b = {1'b1, op_b.f.mantissa};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side_q <= '0;
            side   <= '0;
        end else begin
            side_q <= side_in;
            side   <= side_q;
        end
    end

    always_ff @(posedge clk) begin
        // first cycle forms two 24x12 partial products
        sign_q  <= op_a.f.sign ^ op_b.f.sign;
        exp_q   <= $signed({2'b00, op_a.f.exponent}) + $signed({2'b00, op_b.f.exponent})
                   - 10'(fma_pkg::EXP_BIAS);
        pp_lo_q <= mant_a * mant_b[11:0];
        pp_hi_q <= mant_a * mant_b[23:12];
        op_c_q  <= op_c_in;
        // second cycle adds them into the Q2.46 product
        prod.sign     <= sign_q;
        prod.exponent <= exp_q;
        prod.mant     <= {12'b0, pp_lo_q} + {pp_hi_q, 12'b0};
        op_c          <= op_c_q;
    end

endmodule

//--- hw/fma_align.sv
`timescale 1ns/10ps

module fma_align (
    input  logic                clk,
    input  logic                rst,
    input  fma_pkg::fma_side_t  side_in,
    input  fma_pkg::fma_prod_t  prod,
    input  fma_pkg::fp_word_u   op_c,
    output fma_pkg::fma_side_t  side,
    output fma_pkg::fma_align_t aligned
);

    logic [26:0]         prod_mant;
    logic signed [9:0]   prod_exp;
    // product bits below the 27-bit window
    logic                prod_rest;
    logic [26:0]         c_mant;
    logic signed [9:0]   c_exp;
    logic                c_zero;
    logic                prod_larger;
    logic [9:0]          shift;
    logic [26:0]         smaller;
    logic [53:0]         shifted;
    fma_pkg::fma_align_t aligned_d;

    always_comb begin
        if (prod.mant[47]) begin
            prod_mant = prod.mant[47:21];
            prod_exp  = prod.exponent + 10'sd1;
            prod_rest = |prod.mant[20:0];
        end else begin
            prod_mant = prod.mant[46:20];
            prod_exp  = prod.exponent;
            prod_rest = |prod.mant[19:0];
        end
        c_zero      = op_c.f.exponent == '0;
        c_mant      = {~c_zero, op_c.f.mantissa, 3'b000};
        c_exp       = {2'b00, op_c.f.exponent};
        prod_larger = c_zero || (prod_exp > c_exp)
                      || ((prod_exp == c_exp) && (prod_mant >= c_mant));

        if (prod_larger) begin
            shift                 = prod_exp - c_exp;
            smaller               = c_mant;
            aligned_d.larger_mant = prod_mant;
            aligned_d.exponent    = prod_exp;
            aligned_d.sign        = prod.sign;
        end else begin
            shift                 = c_exp - prod_exp;
            smaller               = prod_mant;
            aligned_d.larger_mant = c_mant;
            aligned_d.exponent    = c_exp;
            aligned_d.sign        = op_c.f.sign;
        end

        shifted                = {smaller, 27'b0} >> shift;
        aligned_d.smaller_mant = shifted[53:27];
        aligned_d.sticky       = prod_rest | ((shift >= 10'd54) ? |smaller : |shifted[26:0]);
        aligned_d.is_sub       = prod.sign ^ op_c.f.sign;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side <= '0;
        end else begin
            side <= side_in;
        end
    end

    always_ff @(posedge clk) begin
        aligned <= aligned_d;
    end

endmodule

//--- hw/fma_add_sub.sv
`timescale 1ns/10ps

module fma_add_sub (
    input  logic                clk,
    input  logic                rst,
    input  fma_pkg::fma_side_t  side_in,
    input  fma_pkg::fma_align_t aligned,
    output fma_pkg::fma_side_t  side,
    output fma_pkg::fma_sum_t   sum
);

    fma_pkg::fma_sum_t sum_d;

    always_comb begin
        // carry kept in bit 27
        sum_d.sum        = {1'b0, aligned.larger_mant} + {1'b0, aligned.smaller_mant};
        // larger minus smaller never goes negative
        sum_d.diff       = aligned.larger_mant - aligned.smaller_mant;
        sum_d.is_sub     = aligned.is_sub;
        sum_d.sticky     = aligned.sticky;
        sum_d.exact_zero = aligned.is_sub && (aligned.larger_mant == aligned.smaller_mant);
        sum_d.exponent   = aligned.exponent;
        sum_d.sign       = aligned.sign;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side <= '0;
        end else begin
            side <= side_in;
        end
    end

    always_ff @(posedge clk) begin
        sum <= sum_d;
    end

endmodule

//--- hw/fma_round.sv
`timescale 1ns/10ps

module fma_round (
    input  logic                clk,
    input  logic                rst,
    input  fma_pkg::fma_side_t  side_in,
    input  fma_pkg::fma_sum_t   sum,
    output fma_pkg::fp_word_u   result,
    output fma_pkg::fma_flags_t flags,
    output logic                valid_out
);

    logic [4:0]          lz;
    logic [26:0]         diff_norm;
    logic [22:0]         mant;
    logic signed [9:0]   exp_n;
    logic                guard;
    logic                round;
    logic                sticky;
    logic                grs;
    logic                inc;
    logic [23:0]         mant_r;
    logic signed [9:0]   exp_r;
    logic                ovf;
    logic                unf;
    logic                to_inf;
    fma_pkg::fp_word_u   result_d;
    fma_pkg::fma_flags_t flags_d;

    // leading zero count of the difference
    always_comb begin
        lz = '0;
        for (int i = 0; i < 27; i++) begin
            if (sum.diff[i]) lz = 5'(26 - i);
        end
        diff_norm = sum.diff << lz;
    end

    always_comb begin
        if (sum.is_sub) begin
            mant   = diff_norm[25:3];
            guard  = diff_norm[2];
            round  = diff_norm[1];
            sticky = diff_norm[0] | sum.sticky;
            exp_n  = sum.exponent - $signed({5'b00000, lz});
        end else if (sum.sum[27]) begin
            mant   = sum.sum[26:4];
            guard  = sum.sum[3];
            round  = sum.sum[2];
            sticky = (|sum.sum[1:0]) | sum.sticky;
            exp_n  = sum.exponent + 10'sd1;
        end else begin
            mant   = sum.sum[25:3];
            guard  = sum.sum[2];
            round  = sum.sum[1];
            sticky = sum.sum[0] | sum.sticky;
            exp_n  = sum.exponent;
        end
        grs = guard | round | sticky;

        case (side_in.rounding_mode)
            fma_pkg::RTZ: inc = 1'b0;
            fma_pkg::RDN: inc = sum.sign & grs;
            fma_pkg::RUP: inc = ~sum.sign & grs;
            default:      inc = guard & (round | sticky | mant[0]);
        endcase

        // a mantissa carry clears the fraction and bumps the exponent
        mant_r = {1'b0, mant} + 24'(inc);
        exp_r  = mant_r[23] ? exp_n + 10'sd1 : exp_n;
        ovf    = exp_r >= 10'sd255;
        unf    = exp_r <= 10'sd0;

        case (side_in.rounding_mode)
            fma_pkg::RTZ: to_inf = 1'b0;
            fma_pkg::RDN: to_inf = sum.sign;
            fma_pkg::RUP: to_inf = ~sum.sign;
            default:      to_inf = 1'b1;
        endcase
    end

    always_comb begin
        result_d.raw      = '0;
        flags_d.overflow  = 1'b0;
        flags_d.underflow = 1'b0;
        flags_d.inexact   = 1'b0;
        flags_d.invalid   = side_in.invalid;
        if (side_in.special_case) begin
            result_d          = side_in.special_result;
            flags_d.underflow = side_in.flushed;
        end else if (sum.exact_zero) begin
            result_d.raw      = {side_in.rounding_mode == fma_pkg::RDN, 31'b0};
            flags_d.underflow = side_in.flushed;
        end else if (ovf) begin
            // infinity or largest finite by mode and sign
            result_d.f.sign     = sum.sign;
            result_d.f.exponent = to_inf ? 8'hff : 8'hfe;
            result_d.f.mantissa = to_inf ? '0 : '1;
            flags_d.overflow    = 1'b1;
            flags_d.inexact     = 1'b1;
        end else if (unf) begin
            result_d.raw      = {sum.sign, 31'b0};
            flags_d.underflow = grs;
            flags_d.inexact   = grs;
        end else begin
            result_d.f.sign     = sum.sign;
            result_d.f.exponent = exp_r[7:0];
            result_d.f.mantissa = mant_r[22:0];
            flags_d.inexact     = grs;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            flags     <= '0;
            valid_out <= 1'b0;
        end else begin
            result    <= result_d;
            flags     <= flags_d;
            valid_out <= side_in.valid;
        end
    end

endmodule

//--- hw/fma_top.sv
`timescale 1ns/10ps

module fma_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  fma_pkg::fp_word_u    in1,
    input  fma_pkg::fp_word_u    in2,
    input  fma_pkg::fp_word_u    in3,
    input  fma_pkg::round_mode_e rounding_mode,
    output fma_pkg::fp_word_u    result,
    output fma_pkg::fma_flags_t  flags,
    output logic                 valid_out
);

    fma_pkg::fma_side_t  side_s1;
    fma_pkg::fma_side_t  side_s3;
    fma_pkg::fma_side_t  side_s4;
    fma_pkg::fma_side_t  side_s5;
    fma_pkg::fp_word_u   op_a;
    fma_pkg::fp_word_u   op_b;
    fma_pkg::fp_word_u   op_c_s1;
    fma_pkg::fp_word_u   op_c_s3;
    fma_pkg::fma_prod_t  prod;
    fma_pkg::fma_align_t aligned;
    fma_pkg::fma_sum_t   sum;

    fma_classify u_classify (
        .clk(clk), .rst(rst), .valid_in(valid_in),
        .in1(in1), .in2(in2), .in3(in3), .rounding_mode(rounding_mode),
        .side(side_s1), .op_a(op_a), .op_b(op_b), .op_c(op_c_s1)
    );

    // stages 2 and 3
    fma_multiplier u_multiplier (
        .clk(clk), .rst(rst), .side_in(side_s1),
        .op_a(op_a), .op_b(op_b), .op_c_in(op_c_s1),
        .side(side_s3), .prod(prod), .op_c(op_c_s3)
    );

    fma_align u_align (
        .clk(clk), .rst(rst), .side_in(side_s3), .prod(prod), .op_c(op_c_s3),
        .side(side_s4), .aligned(aligned)
    );

    fma_add_sub u_add_sub (
        .clk(clk), .rst(rst), .side_in(side_s4), .aligned(aligned),
        .side(side_s5), .sum(sum)
    );

    fma_round u_round (
        .clk(clk), .rst(rst), .side_in(side_s5), .sum(sum),
        .result(result), .flags(flags), .valid_out(valid_out)
    );

endmodule

//--- testbench/fma_checker.sv
`timescale 1ns/10ps

module fma_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 valid_in,
    input fma_pkg::fp_word_u    in1,
    input fma_pkg::fp_word_u    in2,
    input fma_pkg::fp_word_u    in3,
    input fma_pkg::round_mode_e rounding_mode,
    input fma_pkg::fp_word_u    result,
    input fma_pkg::fma_flags_t  flags,
    input logic                 valid_out
);

    // expected word in [35:4], flags {ovf, unf, inx, inv} in [3:0]
    logic [35:0] expect_q [$];
    int          cycle_q [$];
    int          cycle = 0;
    int          pending = 0;
    int          checks = 0;
    int          errors = 0;

    function automatic logic [35:0] fma_model(input logic [31:0] a, b, c, input logic [2:0] mode);
        logic [31:0]  w [3];
        logic [2:0]   zero;
        logic [2:0]   dnrm;
        logic [2:0]   inf;
        logic [2:0]   qnan;
        logic [2:0]   snan;
        logic         sp;
        logic         s;
        logic         inv;
        logic         flush;
        logic         up;
        logic         guard;
        logic         rest;
        logic         to_inf;
        logic [255:0] pv;
        logic [255:0] cv;
        logic [255:0] mag;
        logic [23:0]  man;
        logic [24:0]  mr;
        int           ep;
        int           ec;
        int           d;
        int           base;
        int           msb;
        int           shift;
        int           e;
        w[0] = a;
        w[1] = b;
        w[2] = c;
        for (int i = 0; i < 3; i++) begin
            zero[i] = w[i][30:23] == 8'h00;
            dnrm[i] = zero[i] && (w[i][22:0] != 0);
            inf[i]  = (w[i][30:23] == 8'hff) && (w[i][22:0] == 0);
            qnan[i] = (w[i][30:23] == 8'hff) && w[i][22];
            snan[i] = (w[i][30:23] == 8'hff) && (w[i][22:0] != 0) && !w[i][22];
        end
        sp    = a[31] ^ b[31];
        flush = |dnrm;
        inv   = (|snan) || ((zero[0] || zero[1]) && (inf[0] || inf[1]))
                || ((inf[0] || inf[1]) && inf[2] && (sp != c[31]));
        if (|qnan) return {qnan[0] ? a : (qnan[1] ? b : c), 1'b0, flush, 1'b0, inv};
        if (|snan) begin
            return {(snan[0] ? a : (snan[1] ? b : c)) | 32'h0040_0000,
                    1'b0, flush, 1'b0, inv};
        end
        if (inv) return {32'h7fc0_0000, 1'b0, flush, 1'b0, inv};
        if (inf[0] || inf[1]) return {sp, 8'hff, 23'b0, 1'b0, flush, 2'b00};
        if (inf[2]) return {c, 1'b0, flush, 2'b00};
        if ((zero[0] || zero[1]) && zero[2]) begin
            return {(sp == c[31]) ? sp : (mode == 3'd2), 31'b0, 1'b0, flush, 2'b00};
        end
        if (zero[0] || zero[1]) return {c, 1'b0, flush, 2'b00};

        // exact sum on a wide integer grid with a far operand kept as a lone low bit
        pv = {1'b1, a[22:0]};
        pv = pv * {1'b1, b[22:0]};
        ep = int'(a[30:23]) + int'(b[30:23]) - 300;
        cv = zero[2] ? 256'd0 : 256'({1'b1, c[22:0]});
        ec = zero[2] ? ep : int'(c[30:23]) - 150;
        if (ep >= ec) begin
            d    = ep - ec;
            base = ec;
            if (d > 200) begin
                d    = 100;
                base = ep - 100;
                cv   = 256'(cv != 0);
            end
            pv = pv << d;
        end else begin
            d    = ec - ep;
            base = ep;
            if (d > 200) begin
                d    = 100;
                base = ec - 100;
                pv   = 256'(pv != 0);
            end
            cv = cv << d;
        end
        if (sp == c[31]) begin
            mag = pv + cv;
            s   = sp;
        end else if (pv >= cv) begin
            mag = pv - cv;
            s   = sp;
        end else begin
            mag = cv - pv;
            s   = c[31];
        end
        if (mag == 0) return {mode == 3'd2, 31'b0, 1'b0, flush, 2'b00};

        msb = 0;
        for (int i = 0; i < 256; i++) begin
            if (mag[i]) msb = i;
        end
        e     = msb + base + 127;
        guard = 1'b0;
        rest  = 1'b0;
        if (msb >= 23) begin
            shift = msb - 23;
            man   = 24'(mag >> shift);
            if (shift > 0) begin
                guard = mag[shift-1];
                rest  = (mag << (257 - shift)) != 0;
            end
        end else begin
            man = 24'(mag << (23 - msb));
        end
        case (mode)
            3'd1:    up = 1'b0;
            3'd2:    up = s & (guard | rest);
            3'd3:    up = ~s & (guard | rest);
            default: up = guard & (rest | man[0]);
        endcase
        case (mode)
            3'd1:    to_inf = 1'b0;
            3'd2:    to_inf = s;
            3'd3:    to_inf = ~s;
            default: to_inf = 1'b1;
        endcase
        mr = {1'b0, man} + 25'(up);
        if (mr[24]) begin
            e  = e + 1;
            mr = mr >> 1;
        end
        if (e >= 255) begin
            return to_inf ? {s, 8'hff, 23'b0, 4'b1010} : {s, 8'hfe, 23'h7fffff, 4'b1010};
        end
        if (e <= 0) return {s, 31'b0, 1'b0, guard | rest, guard | rest, 1'b0};
        return {s, 8'(e), mr[22:0], 2'b00, guard | rest, 1'b0};
    endfunction

    always @(negedge clk) begin
        logic [35:0] exp_v;
        int          lat;
        cycle++;
        if (!rst && valid_out) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("unexpected valid_out at %0t with no operation pending", $time);
            end else begin
                exp_v = expect_q.pop_front();
                lat   = cycle - cycle_q.pop_front();
                checks++;
                if (result.raw !== exp_v[35:4]) begin
                    errors++;
                    $display("error at %0t: result expected %h got %h", $time, exp_v[35:4],
                             result.raw);
                end
                if (flags !== exp_v[3:0]) begin
                    errors++;
                    $display("error at %0t: flags expected %b got %b", $time, exp_v[3:0], flags);
                end
                if (lat != 6) begin
                    errors++;
                    $display("error at %0t: valid_out latency expected 6 got %0d", $time, lat);
                end
            end
        end else if (!rst && (cycle_q.size() != 0) && (cycle - cycle_q[0] >= 6)) begin
            // no result six cycles after the strobe
            errors++;
            $display("valid_out missing at %0t for the operation sampled in cycle %0d", $time,
                     cycle_q[0]);
            exp_v = expect_q.pop_front();
            lat   = cycle_q.pop_front();
        end
        if (!rst && valid_in) begin
            expect_q.push_back(fma_model(in1.raw, in2.raw, in3.raw, 3'(rounding_mode)));
            cycle_q.push_back(cycle);
        end
        pending = expect_q.size();
    end

endmodule

//--- testbench/fma_assertions.sv
`timescale 1ns/10ps

module fma_assertions (
    input logic                clk,
    input logic                rst,
    input logic                valid_in,
    input logic                valid_out,
    input fma_pkg::fp_word_u   result,
    input fma_pkg::fma_flags_t flags
);

    int fail_count = 0;

    a_reset_quiet: assert property (@(posedge clk) rst |-> !valid_out)
        else begin
            fail_count++;
            $error("valid_out high during reset");
        end

    // six stages between strobe and result
    a_latency_fwd: assert property (@(posedge clk) disable iff (rst) valid_in |-> ##6 valid_out)
        else begin
            fail_count++;
            $error("valid_out missing six cycles after valid_in");
        end

    a_latency_back: assert property (@(posedge clk) disable iff (rst)
                                     valid_out |-> $past(valid_in, 6))
        else begin
            fail_count++;
            $error("valid_out without valid_in six cycles earlier");
        end

    a_ovf_inexact: assert property (@(posedge clk) disable iff (rst)
                                    valid_out && flags.overflow |-> flags.inexact)
        else begin
            fail_count++;
            $error("overflow raised without inexact");
        end

    a_invalid_nan: assert property (@(posedge clk) disable iff (rst)
                                    valid_out && flags.invalid
                                    |-> result.f.exponent == 8'hff && result.f.mantissa != '0)
        else begin
            fail_count++;
            $error("invalid raised on a result that is not a NaN");
        end

endmodule

bind fma_top fma_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .valid_in(valid_in),
    .valid_out(valid_out),
    .result(result),
    .flags(flags)
);

//--- testbench/fma_tb.sv
`timescale 1ns/10ps

module fma_tb;

    localparam int          N_VEC  = 214;
    localparam logic [31:0] ONE    = 32'h3f80_0000;
    localparam logic [31:0] QNAN_W = 32'h7fc1_2345;
    localparam logic [31:0] SNAN_W = 32'h7f80_0abc;

    logic                 clk;
    logic                 rst;
    logic                 valid_in;
    fma_pkg::fp_word_u    in1;
    fma_pkg::fp_word_u    in2;
    fma_pkg::fp_word_u    in3;
    fma_pkg::round_mode_e rounding_mode;
    fma_pkg::fp_word_u    result;
    fma_pkg::fma_flags_t  flags;
    logic                 valid_out;
    integer               seed;

    fma_top u_dut (
        .clk(clk), .rst(rst), .valid_in(valid_in),
        .in1(in1), .in2(in2), .in3(in3), .rounding_mode(rounding_mode),
        .result(result), .flags(flags), .valid_out(valid_out)
    );

    fma_checker u_chk (
        .clk(clk), .rst(rst), .valid_in(valid_in),
        .in1(in1), .in2(in2), .in3(in3), .rounding_mode(rounding_mode),
        .result(result), .flags(flags), .valid_out(valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one slot per vector plus reset, pipeline fill and margin
    initial begin
        #((N_VEC + 20) * 10);
        $display("watchdog expired with %0d results still pending", u_chk.pending);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic send(input logic [31:0] a, b, c, input logic [2:0] m);
        @(posedge clk);
        #1;
        valid_in      = 1'b1;
        in1.raw       = a;
        in2.raw       = b;
        in3.raw       = c;
        rounding_mode = fma_pkg::round_mode_e'(m);
    endtask

    function automatic logic [31:0] int_to_fp(input int v);
        int          mag;
        int          msb;
        logic [23:0] frac;
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) msb = i;
        end
        frac = 24'(mag) << (23 - msb);
        if (mag == 0) return 32'h0;
        return {v < 0, 8'(127 + msb), frac[22:0]};
    endfunction

    // qnan, snan, inf, zero, denormal, or a small exact normal
    function automatic logic [31:0] special_word(input logic [31:0] r);
        case (r[3:1])
            3'd0:    return {r[31], 8'hff, 1'b1, r[26:5]};
            3'd1:    return {r[31], 8'hff, 1'b0, r[26:6], 1'b1};
            3'd2:    return {r[31], 8'hff, 23'b0};
            3'd3:    return {r[31], 31'b0};
            3'd4:    return {r[31], 8'h00, r[26:5], 1'b1};
            3'd5:    return ONE;
            3'd6:    return 32'hc000_0000;
            default: return 32'h4040_0000;
        endcase
    endfunction

    initial begin
        int          a;
        int          b;
        int          c;
        int          total_errors;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] r;
        seed          = 54;
        rst           = 1'b1;
        valid_in      = 1'b0;
        in1.raw       = '0;
        in2.raw       = '0;
        in3.raw       = '0;
        rounding_mode = fma_pkg::RNE;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // exact integers where every fourth sum cancels to zero
        for (int i = 0; i < 60; i++) begin
            if (i % 4 == 3) begin
                a = $random(seed) % 32;
                b = $random(seed) % 32;
                c = -(a * b);
            end else begin
                a = $random(seed) % 1024;
                b = $random(seed) % 1024;
                c = $random(seed) % 1024;
            end
            r = $random(seed);
            send(int_to_fp(a), int_to_fp(b), int_to_fp(c), r[2:0]);
        end

        // rounding of the bare product
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 20; i++) begin
                x = $random(seed);
                y = $random(seed);
                send({x[31], 4'b0111, x[26:0]}, {y[31], 4'b1000, y[26:0]}, 32'h0, 3'(m));
            end
        end

        for (int i = 0; i < 40; i++) begin
            x = $random(seed);
            y = $random(seed);
            z = $random(seed);
            r = $random(seed);
            send(special_word(x), special_word(y), special_word(z), r[2:0]);
        end
        for (int p = 0; p < 3; p++) begin
            send(p == 0 ? QNAN_W : ONE, p == 1 ? QNAN_W : ONE, p == 2 ? QNAN_W : ONE, 3'd0);
            send(p == 0 ? SNAN_W : ONE, p == 1 ? SNAN_W : ONE, p == 2 ? SNAN_W : ONE, 3'd0);
        end
        send(32'h7f80_0000, 32'h0, ONE, 3'd0);
        send(32'h7f80_0000, ONE, 32'hff80_0000, 3'd0);

        // products near 2^200
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 2; k++) begin
                    x = $random(seed);
                    y = $random(seed);
                    send({1'(s), 8'd227, x[22:0]}, {1'b0, 8'd227, y[22:0]}, ONE, 3'(m));
                end
            end
        end

        // denormal in1 flushes to zero
        for (int i = 0; i < 10; i++) begin
            x = $random(seed);
            y = $random(seed);
            z = $random(seed);
            r = $random(seed);
            send({x[31], 8'h00, x[22:1], 1'b1}, {y[31], 2'b10, y[28:0]},
                 {z[31], 2'b01, z[28:0]}, r[2:0]);
        end

        @(posedge clk);
        #1;
        valid_in = 1'b0;
        wait (u_chk.pending == 0);
        @(posedge clk);
        total_errors = u_chk.errors + u_dut.u_assertions.fail_count;
        $display("checks %0d, result errors %0d, assertion failures %0d", u_chk.checks,
                 u_chk.errors, u_dut.u_assertions.fail_count);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/fma_pkg.sv
hw/fma_classify.sv
hw/fma_multiplier.sv
hw/fma_align.sv
hw/fma_add_sub.sv
hw/fma_round.sv
hw/fma_top.sv
testbench/fma_checker.sv
testbench/fma_assertions.sv
testbench/fma_tb.sv

//--- Bender.yml
package:
  name: fma

sources:
  - hw/fma_pkg.sv
  - hw/fma_classify.sv
  - hw/fma_multiplier.sv
  - hw/fma_align.sv
  - hw/fma_add_sub.sv
  - hw/fma_round.sv
  - hw/fma_top.sv
  - target: test
    files:
      - testbench/fma_checker.sv
      - testbench/fma_assertions.sv
      - testbench/fma_tb.sv
